// File: hdl/rom_load_pkg.sv
`default_nettype none

package rom_load_pkg;

    // Host side byte address, as sent with ioctl_wr
    localparam int IOCTL_AW = 25;

    // SDRAM side address, counted in 16-bit halfwords
    localparam int PROG_AW = 22;

    // Region code width
    localparam int REGION_W = 2;

    // Main code, sound code and PCM samples, stored as they come
    localparam logic [REGION_W-1:0] REG_LINEAR = 2'd0;

    // Scroll tiles, low address bits reordered for the tile fetcher
    localparam logic [REGION_W-1:0] REG_SCR = 2'd1;

    // Object tiles, reordered with a wider rule than scroll
    localparam logic [REGION_W-1:0] REG_OBJ = 2'd2;

    // Colour PROMs, these never reach the SDRAM
    localparam logic [REGION_W-1:0] REG_PROM = 2'd3;

endpackage

`default_nettype wire

// File: hdl/dwnld_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dwnld_decode #(
    parameter logic [rom_load_pkg::IOCTL_AW-1:0] SCR_START  = 25'h01_0000,
    parameter logic [rom_load_pkg::IOCTL_AW-1:0] OBJ_START  = 25'h02_0000,
    parameter logic [rom_load_pkg::IOCTL_AW-1:0] PCM_START  = 25'h03_0000,
    parameter logic [rom_load_pkg::IOCTL_AW-1:0] PROM_START = 25'h04_0000
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                downloading,
    input  logic [rom_load_pkg::IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    input  logic                                ioctl_wr,
    output logic                                dec_valid,
    output logic [rom_load_pkg::REGION_W-1:0]   dec_region,
    output logic [rom_load_pkg::PROG_AW-1:0]    dec_addr,
    output logic                                dec_lane,
    output logic [7:0]                          dec_data,
    output logic                                is_alt
);
    import rom_load_pkg::*;

    // Second PROM byte tells the board variant apart
    localparam logic [IOCTL_AW-1:0] ALT_ADDR = PROM_START + 1'b1;

    logic                   host_wr;
    logic                   in_prom;
    logic                   in_scr;
    logic                   in_obj;
    logic [IOCTL_AW-1:0]    prom_off;
    logic [REGION_W-1:0]    next_region;
    logic [PROG_AW-1:0]     next_addr;

    // Strobes outside a download are ignored
    assign host_wr = ioctl_wr && downloading;

    assign in_prom = ioctl_addr >= PROM_START;
    assign in_scr  = (ioctl_addr >= SCR_START) && (ioctl_addr < OBJ_START);
    assign in_obj  = (ioctl_addr >= OBJ_START) && (ioctl_addr < PCM_START);

    assign prom_off = ioctl_addr - PROM_START;

    always_comb begin
        if (in_prom) begin
            next_region = REG_PROM;
        end else if (in_scr) begin
            next_region = REG_SCR;
        end else if (in_obj) begin
            next_region = REG_OBJ;
        end else begin
            next_region = REG_LINEAR;
        end
    end

    // PROMs are byte wide, so they keep the byte offset
    always_comb begin
        if (in_prom) begin
            next_addr = prom_off[PROG_AW-1:0];
        end else begin
            next_addr = ioctl_addr[PROG_AW:1];
        end
    end

    // Pipeline valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= host_wr;
        end
    end

    // Payload only moves with a host write
    always_ff @(posedge clk) begin
        if (host_wr) begin
            dec_region <= next_region;
            dec_addr   <= next_addr;
            dec_lane   <= ioctl_addr[0];
            dec_data   <= ioctl_dout;
        end
    end

    // All ones at the second PROM byte selects the alternate board
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_alt <= 1'b0;
        end else if (host_wr && (ioctl_addr == ALT_ADDR)) begin
            is_alt <= &ioctl_dout;
        end
    end

endmodule

`default_nettype wire

// File: hdl/gfx_swizzle.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_swizzle (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                dec_valid,
    input  logic [rom_load_pkg::REGION_W-1:0]   dec_region,
    input  logic [rom_load_pkg::PROG_AW-1:0]    dec_addr,
    input  logic                                dec_lane,
    input  logic [7:0]                          dec_data,
    output logic                                swz_valid,
    output logic [rom_load_pkg::REGION_W-1:0]   swz_region,
    output logic [rom_load_pkg::PROG_AW-1:0]    swz_addr,
    output logic                                swz_lane,
    output logic [7:0]                          swz_data
);
    import rom_load_pkg::*;

    logic [PROG_AW-1:0] perm_addr;

    // Tile rows end up next to each other in memory, so the video side
    // can read a whole tile line with one linear burst
    always_comb begin
        perm_addr = dec_addr;
        case (dec_region)
            REG_SCR: begin
                perm_addr[3:0] = {dec_addr[2:0], ~dec_addr[3]};
            end
            REG_OBJ: begin
                // Objects are twice as wide, two bits move instead of one
                perm_addr[4:0] = {dec_addr[2:0], ~dec_addr[4], ~dec_addr[3]};
            end
            default: begin
                perm_addr = dec_addr;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swz_valid <= 1'b0;
        end else begin
            swz_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            swz_region <= dec_region;
            swz_addr   <= perm_addr;
            swz_lane   <= dec_lane;
            swz_data   <= dec_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sdram_prog_port.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_prog_port (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                downloading,
    input  logic                                swz_valid,
    input  logic [rom_load_pkg::REGION_W-1:0]   swz_region,
    input  logic [rom_load_pkg::PROG_AW-1:0]    swz_addr,
    input  logic                                swz_lane,
    input  logic [7:0]                          swz_data,
    input  logic                                sdram_ack,
    output logic [rom_load_pkg::PROG_AW-1:0]    prog_addr,
    output logic [7:0]                          prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_we,
    output logic                                prom_we,
    output logic                                port_busy,
    output logic                                dwnld_ovf
);
    import rom_load_pkg::*;

    logic                   skid_valid;
    logic                   skid_prom;
    logic                   skid_lane;
    logic [PROG_AW-1:0]     skid_addr;
    logic [7:0]             skid_data;

    logic                   in_prom;
    logic                   out_free;
    logic                   take_skid;
    logic                   take_in;
    logic                   load_out;
    logic                   push_skid;
    logic                   drop;

    logic                   sel_prom;
    logic                   sel_lane;
    logic [PROG_AW-1:0]     sel_addr;
    logic [7:0]             sel_data;

    logic                   dl_q;

    assign in_prom = swz_region == REG_PROM;

    // Output can take an item next cycle once the pending write is acked
    assign out_free = !prog_we || sdram_ack;

    // Skid always goes first so the write order is kept
    assign take_skid = skid_valid && out_free;
    assign take_in   = swz_valid && out_free && !skid_valid;
    assign load_out  = take_skid || take_in;
    assign push_skid = swz_valid && !take_in && (!skid_valid || take_skid);
    assign drop      = swz_valid && skid_valid && !take_skid;

    assign sel_prom = skid_valid ? skid_prom : in_prom;
    assign sel_lane = skid_valid ? skid_lane : swz_lane;
    assign sel_addr = skid_valid ? skid_addr : swz_addr;
    assign sel_data = skid_valid ? skid_data : swz_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
        end else if (push_skid) begin
            skid_valid <= 1'b1;
        end else if (take_skid) begin
            skid_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push_skid) begin
            skid_prom <= in_prom;
            skid_lane <= swz_lane;
            skid_addr <= swz_addr;
            skid_data <= swz_data;
        end
    end

    // prog_we holds until acked, prom_we is a single pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else if (load_out) begin
            prog_we <= !sel_prom;
            prom_we <= sel_prom;
        end else begin
            prom_we <= 1'b0;
            if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    // Byte swap: even byte in the upper lane, mask is active low
    always_ff @(posedge clk) begin
        if (load_out) begin
            prog_addr <= sel_addr;
            prog_data <= sel_data;
            prog_mask <= {sel_lane, ~sel_lane};
        end
    end

    // Sticky overflow, a fresh download starts clean
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dl_q      <= 1'b0;
            dwnld_ovf <= 1'b0;
        end else begin
            dl_q <= downloading;
            if (downloading && !dl_q) begin
                dwnld_ovf <= 1'b0;
            end else if (drop) begin
                dwnld_ovf <= 1'b1;
            end
        end
    end

    assign port_busy = prog_we || prom_we || skid_valid;

endmodule

`default_nettype wire

// File: hdl/rom_load_top.sv
`timescale 1ns/1ps
`default_nettype none

module rom_load_top #(
    parameter logic [rom_load_pkg::IOCTL_AW-1:0] SCR_START  = 25'h01_0000,
    parameter logic [rom_load_pkg::IOCTL_AW-1:0] OBJ_START  = 25'h02_0000,
    parameter logic [rom_load_pkg::IOCTL_AW-1:0] PCM_START  = 25'h03_0000,
    parameter logic [rom_load_pkg::IOCTL_AW-1:0] PROM_START = 25'h04_0000
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                downloading,
    input  logic [rom_load_pkg::IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    input  logic                                ioctl_wr,
    input  logic                                sdram_ack,
    output logic [rom_load_pkg::PROG_AW-1:0]    prog_addr,
    output logic [7:0]                          prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_we,
    output logic                                prom_we,
    output logic                                is_alt,
    output logic                                dwnld_busy,
    output logic                                dwnld_ovf
);
    import rom_load_pkg::*;

    logic                   dec_valid;
    logic [REGION_W-1:0]    dec_region;
    logic [PROG_AW-1:0]     dec_addr;
    logic                   dec_lane;
    logic [7:0]             dec_data;

    logic                   swz_valid;
    logic [REGION_W-1:0]    swz_region;
    logic [PROG_AW-1:0]     swz_addr;
    logic                   swz_lane;
    logic [7:0]             swz_data;

    logic                   port_busy;

    dwnld_decode #(
        .SCR_START  (SCR_START),
        .OBJ_START  (OBJ_START),
        .PCM_START  (PCM_START),
        .PROM_START (PROM_START)
    ) u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .dec_valid   (dec_valid),
        .dec_region  (dec_region),
        .dec_addr    (dec_addr),
        .dec_lane    (dec_lane),
        .dec_data    (dec_data),
        .is_alt      (is_alt)
    );

    gfx_swizzle u_swizzle (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .dec_region (dec_region),
        .dec_addr   (dec_addr),
        .dec_lane   (dec_lane),
        .dec_data   (dec_data),
        .swz_valid  (swz_valid),
        .swz_region (swz_region),
        .swz_addr   (swz_addr),
        .swz_lane   (swz_lane),
        .swz_data   (swz_data)
    );

    sdram_prog_port u_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .swz_valid   (swz_valid),
        .swz_region  (swz_region),
        .swz_addr    (swz_addr),
        .swz_lane    (swz_lane),
        .swz_data    (swz_data),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .port_busy   (port_busy),
        .dwnld_ovf   (dwnld_ovf)
    );

    // Busy until the last byte has left every stage
    assign dwnld_busy = downloading || dec_valid || swz_valid || port_busy;

endmodule

`default_nettype wire

// File: bench/rom_load_checks.svh
`ifndef ROM_LOAD_CHECKS_SVH
`define ROM_LOAD_CHECKS_SVH

// Ends the run at the first error
task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping after the first error");
endtask

task automatic check_addr(input logic [PROG_AW-1:0] got, input logic [PROG_AW-1:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("** Error at %0t: %s address %h, expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_data(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
        $display("** Error at %0t: %s data %h, expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

// Mask is active low, 01 for an even byte
task automatic check_mask(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) begin
        $display("** Error at %0t: %s mask %b, expected %b", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        abort_run();
    end
endtask

`endif

// File: bench/rom_load_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rom_load_tb;
    import rom_load_pkg::*;

    `include "rom_load_checks.svh"

    // Small region map so every region is reached with short addresses
    localparam logic [IOCTL_AW-1:0] SCR_START  = 25'h100;
    localparam logic [IOCTL_AW-1:0] OBJ_START  = 25'h200;
    localparam logic [IOCTL_AW-1:0] PCM_START  = 25'h300;
    localparam logic [IOCTL_AW-1:0] PROM_START = 25'h400;

    // Host bytes over all tests
    localparam int N_BYTES    = 73;
    localparam int MAX_CYCLES = 40 * N_BYTES + 200;

    logic                   clk;
    logic                   rst_n;
    logic                   downloading;
    logic [IOCTL_AW-1:0]    ioctl_addr;
    logic [7:0]             ioctl_dout;
    logic                   ioctl_wr;
    logic                   sdram_ack;
    logic [PROG_AW-1:0]     prog_addr;
    logic [7:0]             prog_data;
    logic [1:0]             prog_mask;
    logic                   prog_we;
    logic                   prom_we;
    logic                   is_alt;
    logic                   dwnld_busy;
    logic                   dwnld_ovf;

    // Entries are {addr, data, mask} and {addr, data}
    logic [PROG_AW+9:0]     got_wr[$];
    logic [PROG_AW+9:0]     exp_wr[$];
    logic [PROG_AW+7:0]     got_prom[$];
    logic [PROG_AW+7:0]     exp_prom[$];

    integer                 seed;
    int unsigned            ack_wait;
    logic                   ack_busy;
    logic                   ack_hold;
    int                     cycles;

    rom_load_top #(
        .SCR_START  (SCR_START),
        .OBJ_START  (OBJ_START),
        .PCM_START  (PCM_START),
        .PROM_START (PROM_START)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .is_alt      (is_alt),
        .dwnld_busy  (dwnld_busy),
        .dwnld_ovf   (dwnld_ovf)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run hung after %0d cycles", cycles);
            abort_run();
        end
    end

    // SDRAM controller model that acks a write after 0 to 6 cycles
    always @(negedge clk) begin
        sdram_ack = 1'b0;
        if (prom_we) begin
            got_prom.push_back({prog_addr, prog_data});
        end
        if (prog_we && !ack_hold) begin
            if (!ack_busy) begin
                ack_busy = 1'b1;
                ack_wait = {$random(seed)} % 7;
            end
            if (ack_wait == 0) begin
                sdram_ack = 1'b1;
                ack_busy  = 1'b0;
                got_wr.push_back({prog_addr, prog_data, prog_mask});
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    // Halfword address that the region rules give for a byte address
    function automatic logic [PROG_AW-1:0] expected_addr(input logic [IOCTL_AW-1:0] a);
        logic [IOCTL_AW-1:0]    off;
        logic [PROG_AW-1:0]     h;
        logic [PROG_AW-1:0]     r;
        off = a - PROM_START;
        h = a[PROG_AW:1];
        r = h;
        if (a >= PROM_START) begin
            r = off[PROG_AW-1:0];
        end else if (a >= SCR_START && a < OBJ_START) begin
            r[3:0] = {h[2], h[1], h[0], ~h[3]};
        end else if (a >= OBJ_START && a < PCM_START) begin
            r[4:0] = {h[2], h[1], h[0], ~h[4], ~h[3]};
        end
        return r;
    endfunction

    task automatic host_write(input logic [IOCTL_AW-1:0] a, input logic [7:0] d, input int gap);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        repeat (gap - 1) @(negedge clk);
    endtask

    task automatic send_byte(input logic [IOCTL_AW-1:0] a, input logic [7:0] d, input int gap);
        if (a >= PROM_START) begin
            exp_prom.push_back({expected_addr(a), d});
        end else begin
            exp_wr.push_back({expected_addr(a), d, a[0] ? 2'b10 : 2'b01});
        end
        host_write(a, d, gap);
    endtask

    task automatic start_download();
        downloading = 1'b1;
        @(negedge clk);
    endtask

    task automatic finish_download();
        downloading = 1'b0;
        @(negedge clk);
        while (dwnld_busy) @(negedge clk);
    endtask

    task automatic compare_results(input string name);
        logic [PROG_AW+9:0] g;
        logic [PROG_AW+9:0] e;
        logic [PROG_AW+7:0] gp;
        logic [PROG_AW+7:0] ep;
        if (got_wr.size() != exp_wr.size() || got_prom.size() != exp_prom.size()) begin
            $display("%s: saw %0d SDRAM and %0d PROM writes, expected %0d and %0d", name,
                     got_wr.size(), got_prom.size(), exp_wr.size(), exp_prom.size());
            abort_run();
        end
        foreach (exp_wr[i]) begin
            g = got_wr[i];
            e = exp_wr[i];
            check_addr(g[PROG_AW+9:10], e[PROG_AW+9:10], name);
            check_data(g[9:2], e[9:2], name);
            check_mask(g[1:0], e[1:0], name);
        end
        foreach (exp_prom[i]) begin
            gp = got_prom[i];
            ep = exp_prom[i];
            check_addr(gp[PROG_AW+7:8], ep[PROG_AW+7:8], {name, " PROM"});
            check_data(gp[7:0], ep[7:0], {name, " PROM"});
        end
        got_wr.delete();
        exp_wr.delete();
        got_prom.delete();
        exp_prom.delete();
    endtask

    task automatic test_linear();
        start_download();
        for (int i = 0; i < 4; i++) begin
            send_byte(25'h10 + i, 8'ha0 + i, 8);
        end
        send_byte(PCM_START, 8'h5c, 8);
        send_byte(PCM_START + 1, 8'hc5, 8);
        finish_download();
        compare_results("linear");
    endtask

    // Every value of the low halfword bits with alternating lanes
    task automatic test_scroll();
        start_download();
        send_byte(SCR_START - 2, 8'h11, 8);
        send_byte(SCR_START - 1, 8'h22, 8);
        for (int i = 0; i < 16; i++) begin
            send_byte(SCR_START + 2 * i + (i & 1), 8'h30 + i, 8);
        end
        send_byte(OBJ_START, 8'h77, 8);
        finish_download();
        compare_results("scroll");
    endtask

    task automatic test_object();
        start_download();
        for (int i = 0; i < 32; i++) begin
            send_byte(OBJ_START + 2 * i + (i & 1), i ^ 8'h96, 8);
        end
        send_byte(PCM_START - 1, 8'he1, 8);
        finish_download();
        compare_results("object");
    endtask

    task automatic test_prom();
        start_download();
        send_byte(PROM_START, 8'h12, 8);
        send_byte(PROM_START + 1, 8'hff, 8);
        send_byte(PROM_START + 2, 8'h34, 8);
        send_byte(PROM_START + 3, 8'h56, 8);
        finish_download();
        compare_results("prom");
        check_flag(is_alt, 1'b1, "is_alt after FF");
        start_download();
        send_byte(PROM_START + 1, 8'h3c, 8);
        finish_download();
        compare_results("prom again");
        check_flag(is_alt, 1'b0, "is_alt after 3C");
    endtask

    // Acks may come later than the next byte
    task automatic test_spaced_writes();
        for (int b = 0; b < 2; b++) begin
            start_download();
            for (int i = 0; i < 3; i++) begin
                send_byte(25'h40 + 25'h110 * b + i, 8'h60 + 8 * b + i, 4);
            end
            downloading = 1'b0;
            @(negedge clk);
            while (got_wr.size() < exp_wr.size()) begin
                check_flag(dwnld_busy, 1'b1, "dwnld_busy before last ack");
                @(negedge clk);
            end
            finish_download();
            compare_results("spaced writes");
            check_flag(dwnld_ovf, 1'b0, "dwnld_ovf after spaced writes");
        end
    endtask

    // Output and skid fill up and the last two bytes are lost
    task automatic test_overflow();
        start_download();
        ack_hold = 1'b1;
        send_byte(25'h80, 8'hd0, 1);
        send_byte(25'h81, 8'hd1, 1);
        host_write(25'h82, 8'hd2, 1);
        host_write(25'h83, 8'hd3, 1);
        repeat (4) @(negedge clk);
        check_flag(dwnld_ovf, 1'b1, "dwnld_ovf after burst");
        ack_hold = 1'b0;
        finish_download();
        compare_results("overflow");
        check_flag(dwnld_ovf, 1'b1, "dwnld_ovf after drain");
        start_download();
        check_flag(dwnld_ovf, 1'b0, "dwnld_ovf on new download");
        finish_download();
    endtask

    initial begin
        seed        = 32'hd564_aa1e;
        cycles      = 0;
        ack_wait    = 0;
        ack_busy    = 1'b0;
        ack_hold    = 1'b0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        sdram_ack   = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_flag(is_alt, 1'b0, "is_alt after reset");
        check_flag(dwnld_busy, 1'b0, "dwnld_busy after reset");
        check_flag(prog_we, 1'b0, "prog_we after reset");
        check_flag(prom_we, 1'b0, "prom_we after reset");
        check_flag(dwnld_ovf, 1'b0, "dwnld_ovf after reset");
        test_linear();
        test_scroll();
        test_object();
        test_prom();
        test_spaced_writes();
        test_overflow();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+bench
hdl/rom_load_pkg.sv
hdl/dwnld_decode.sv
hdl/gfx_swizzle.sv
hdl/sdram_prog_port.sv
hdl/rom_load_top.sv
bench/rom_load_tb.sv
